/* Makefile */
# Verilator build and run for the timer block

VERILATOR ?= verilator
TOP       := opn_timer_ctrl_tb
FILELIST  := opn_timer_ctrl.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --timing --assert --timescale 1ns/10ps
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the run passes only if the log has no fail line and reaches the pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run incomplete, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* opn_timer_ctrl.f */
verilog/opn_bus_pkg.sv
verilog/opn_reg_pkg.sv
verilog/opn_apb_slave.sv
verilog/opn_timer_regs.sv
verilog/opn_timer.sv
verilog/opn_timer_ctrl.sv
tests/opn_timer_ctrl_properties.sv
tests/opn_timer_ctrl_tb.sv

/* tests/opn_timer_ctrl_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module opn_timer_ctrl_properties import opn_bus_pkg::*, opn_reg_pkg::*; (
	input wire logic mclk_i,
	input wire logic arst_n_i,
	input wire apb_req_t apb_i,
	input wire logic pready_i,
	input wire logic pslverr_i,
	input wire logic timer_a_status_i,
	input wire logic timer_b_status_i,
	input wire timer_cfg_t timer_a_cfg_i,
	input wire timer_cfg_t timer_b_cfg_i
);

	a_pready_access: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		pready_i |-> apb_i.psel && apb_i.penable)
		else $error("pready outside an access phase");

	// flag is set at the edge where flag_en was seen high
	a_flag_a_en: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		$rose(timer_a_status_i) |-> $past(timer_a_cfg_i.flag_en))
		else $error("timer A flag rose with its enable low");

	a_flag_b_en: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		$rose(timer_b_status_i) |-> $past(timer_b_cfg_i.flag_en))
		else $error("timer B flag rose with its enable low");

	a_read_no_err: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		apb_i.psel && !apb_i.pwrite |-> !pslverr_i)
		else $error("pslverr on a read");

endmodule

bind opn_timer_ctrl opn_timer_ctrl_properties i_properties (
	.mclk_i(mclk_i),
	.arst_n_i(arst_n_i),
	.apb_i(apb_i),
	.pready_i(pready_o),
	.pslverr_i(pslverr_o),
	.timer_a_status_i(timer_a_status_o),
	.timer_b_status_i(timer_b_status_o),
	.timer_a_cfg_i(timer_a_cfg),
	.timer_b_cfg_i(timer_b_cfg)
);

`default_nettype wire

/* tests/opn_timer_ctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module opn_timer_ctrl_tb import opn_bus_pkg::*, opn_reg_pkg::*; ();

	logic mclk_i = 1'b0;
	logic arst_n_i;
	apb_req_t apb_i;
	logic sample_tick_i;
	logic [pdata_w-1:0] prdata_o;
	logic pready_o;
	logic pslverr_o;
	logic timer_a_status_o;
	logic timer_b_status_o;
	logic mode_ch3_o;
	logic mode_csm_o;

	integer seed;
	int err_count = 0;
	int fail_count = 0;
	int i;
	logic [paddr_w-1:0] addr;
	logic [timer_a_w-1:0] ra;
	logic [timer_b_w-1:0] rb;

	// reference model with bit 0 for timer A and bit 1 for timer B
	logic [timer_a_w-1:0] m_a_load;
	logic [timer_b_w-1:0] m_b_load;
	logic [1:0] m_run;
	logic [1:0] m_run_q;
	logic [1:0] m_en;
	logic [1:0] m_clr;
	logic [1:0] m_flag;
	logic [timer_a_w-1:0] m_cnt_a;
	logic [timer_b_w-1:0] m_cnt_b;
	logic [timer_b_prescale_w-1:0] m_pre;
	timer_mode_e m_mode;
	logic [timer_a_w:0] nxt_a; // msb marks an overflow
	logic [timer_a_w:0] nxt_b;
	logic wr_commit;
	logic exp_err;

	opn_timer_ctrl i_dut (
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.apb_i(apb_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.sample_tick_i(sample_tick_i),
		.timer_a_status_o(timer_a_status_o),
		.timer_b_status_o(timer_b_status_o),
		.mode_ch3_o(mode_ch3_o),
		.mode_csm_o(mode_csm_o)
	);

	always #5 mclk_i = ~mclk_i;

	function automatic logic is_kept_reg(input logic [7:0] num);
		return num == reg_timer_a_lo || num == reg_timer_a_hi ||
			num == reg_timer_b || num == reg_timer_ctrl;
	endfunction

	// next counter value where a step at top reloads instead of wrapping
	function automatic logic [timer_a_w:0] next_count(input logic [9:0] cnt,
		input logic [9:0] load, input logic start, input logic run, input logic step,
		input logic [9:0] top);
		if (start) return {1'b0, load};
		if (!(run && step)) return {1'b0, cnt};
		if (cnt == top) return {1'b1, load};
		return {1'b0, cnt + 10'd1};
	endfunction

	assign wr_commit = apb_i.psel & apb_i.penable & apb_i.pwrite & ~apb_i.paddr[paddr_w-1] &
		is_kept_reg(apb_i.paddr[7:0]);
	assign exp_err = apb_i.psel & apb_i.penable & apb_i.pwrite &
		(apb_i.paddr[paddr_w-1] | ~is_kept_reg(apb_i.paddr[7:0]));

	always @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			m_a_load <= '0;
			m_b_load <= '0;
			m_run <= 2'b00;
			m_run_q <= 2'b00;
			m_en <= 2'b00;
			m_clr <= 2'b00;
			m_flag <= 2'b00;
			m_cnt_a <= '0;
			m_cnt_b <= '0;
			m_pre <= '0;
			m_mode <= mode_normal;
		end else begin
			if (wr_commit) begin
				case (apb_i.paddr[7:0])
					reg_timer_a_lo: m_a_load[7:0] <= apb_i.pwdata;
					reg_timer_a_hi: m_a_load[timer_a_w-1:8] <= apb_i.pwdata[timer_a_w-9:0];
					reg_timer_b: m_b_load <= apb_i.pwdata;
					reg_timer_ctrl: begin
						m_run <= apb_i.pwdata[1:0];
						m_en <= apb_i.pwdata[3:2];
						m_mode <= timer_mode_e'(apb_i.pwdata[7:6]);
					end
					default: ;
				endcase
			end
			m_clr <= (wr_commit && apb_i.paddr[7:0] == reg_timer_ctrl) ?
				apb_i.pwdata[5:4] : 2'b00;
			m_run_q <= m_run;
			m_pre <= m_pre + {{(timer_b_prescale_w-1){1'b0}}, sample_tick_i}; // free running
			nxt_a = next_count(m_cnt_a, m_a_load, m_run[0] & ~m_run_q[0], m_run[0],
				sample_tick_i, 10'h3ff);
			nxt_b = next_count({2'b00, m_cnt_b}, {2'b00, m_b_load}, m_run[1] & ~m_run_q[1],
				m_run[1], sample_tick_i & (&m_pre), 10'h0ff);
			m_cnt_a <= nxt_a[timer_a_w-1:0];
			m_cnt_b <= nxt_b[timer_b_w-1:0];
			if (m_clr[0]) m_flag[0] <= 1'b0;
			else if (nxt_a[timer_a_w] & m_en[0]) m_flag[0] <= 1'b1;
			if (m_clr[1]) m_flag[1] <= 1'b0;
			else if (nxt_b[timer_a_w] & m_en[1]) m_flag[1] <= 1'b1;
		end
	end

	task automatic check_status(input string name, input logic [pdata_w-1:0] exp_v,
		input logic [pdata_w-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp_v, act_v);
			err_count = err_count + 1;
		end
	endtask

	task automatic check_bit(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp_v, act_v);
			err_count = err_count + 1;
		end
	endtask

	task automatic check_mode(input timer_mode_e exp_mode, input logic ch3, input logic csm);
		logic exp_ch3;
		logic exp_csm;
		exp_ch3 = (exp_mode != mode_normal);
		exp_csm = (exp_mode == mode_csm);
		if (ch3 !== exp_ch3 || csm !== exp_csm) begin
			$display("ERR %0t mode_ch3_o,mode_csm_o expected %b%b got %b%b (%s)", $time,
				exp_ch3, exp_csm, ch3, csm, exp_mode.name());
			err_count = err_count + 1;
		end
	endtask

	// outputs have settled 2 ns after the rising edge and inputs move only on the falling edge
	always @(posedge mclk_i) begin
		#2;
		if (arst_n_i) begin
			check_status("prdata_o", {{(pdata_w-2){1'b0}}, m_flag}, prdata_o);
			check_status("timer_b_status_o,timer_a_status_o", {{(pdata_w-2){1'b0}}, m_flag},
				{{(pdata_w-2){1'b0}}, timer_b_status_o, timer_a_status_o});
			check_bit("pready_o", apb_i.psel & apb_i.penable, pready_o);
			check_bit("pslverr_o", exp_err, pslverr_o);
			check_mode(m_mode, mode_ch3_o, mode_csm_o);
		end
	end

	task automatic apb_xfer(input logic write, input logic [paddr_w-1:0] a,
		input logic [pdata_w-1:0] data);
		int n;
		@(negedge mclk_i);
		apb_i.psel = 1'b1;
		apb_i.penable = 1'b0;
		apb_i.pwrite = write;
		apb_i.paddr = a;
		apb_i.pwdata = data;
		@(negedge mclk_i);
		apb_i.penable = 1'b1;
		n = 0;
		do begin
			@(posedge mclk_i);
			n = n + 1;
		end while (!pready_o && n < 8);
		if (!pready_o) begin
			$display("no pready within 8 cycles for address %h", a);
			fail_count = fail_count + 1;
		end
		@(negedge mclk_i);
		apb_i.psel = 1'b0;
		apb_i.penable = 1'b0;
	endtask

	task automatic tick_once();
		int gap;
		gap = $unsigned($random(seed)) % 4;
		@(negedge mclk_i);
		sample_tick_i = 1'b1;
		@(negedge mclk_i);
		sample_tick_i = 1'b0;
		repeat (gap) @(negedge mclk_i);
	endtask

	task automatic wait_flag(input string name, input logic b_sel, input int max_ticks);
		int n;
		n = 0;
		while (n < max_ticks && !(b_sel ? timer_b_status_o : timer_a_status_o)) begin
			tick_once();
			n = n + 1;
		end
		if (n >= max_ticks) begin
			$display("timer %s flag did not rise within %0d ticks", name, max_ticks);
			fail_count = fail_count + 1;
		end
	endtask

	initial begin
		seed = 32'hac7c;
		arst_n_i = 1'b0;
		apb_i = '0;
		sample_tick_i = 1'b0;
		repeat (2) @(posedge mclk_i);
		@(negedge mclk_i);
		arst_n_i = 1'b1;
		repeat (3) @(negedge mclk_i);
		apb_xfer(1'b0, 9'h000, 8'h00);

		ra = 10'h3c0 | (10'($random(seed)) & 10'h01f); // short period keeps the run brief
		apb_xfer(1'b1, {1'b0, reg_timer_a_lo}, ra[7:0]);
		apb_xfer(1'b1, {1'b0, reg_timer_a_hi}, {6'b000000, ra[9:8]});
		apb_xfer(1'b1, {1'b0, reg_timer_ctrl}, 8'h05);
		wait_flag("A", 1'b0, 100);
		repeat (3) tick_once(); // moves the count off its reload value
		apb_xfer(1'b1, {1'b0, reg_timer_ctrl}, 8'h15); // clear A while run stays set
		@(negedge mclk_i); // clear pulse lands on the following edge
		wait_flag("A", 1'b0, 100);

		rb = 8'hf0 | 8'($random(seed));
		apb_xfer(1'b1, {1'b0, reg_timer_b}, rb);
		apb_xfer(1'b1, {1'b0, reg_timer_ctrl}, 8'h0f);
		wait_flag("B", 1'b1, 300);

		// overflows with both enables low
		apb_xfer(1'b1, {1'b0, reg_timer_ctrl}, 8'h33);
		repeat (300) tick_once();

		for (i = 0; i < 10; i++) begin
			addr = 9'($random(seed));
			if (!addr[paddr_w-1] && is_kept_reg(addr[7:0])) addr[paddr_w-1] = 1'b1;
			apb_xfer(1'b1, addr, 8'($random(seed)));
			apb_xfer(1'b0, addr, 8'h00);
		end

		for (i = 0; i < 4; i++) begin
			apb_xfer(1'b1, {1'b0, reg_timer_ctrl}, {2'(i), 6'b000011});
			repeat (2) @(negedge mclk_i);
		end

		for (i = 0; i < 12; i++) begin
			addr = {1'b0, reg_timer_a_lo + 8'($unsigned($random(seed)) % 4)};
			apb_xfer(1'b1, addr, 8'($random(seed)));
			repeat ($unsigned($random(seed)) % 24) tick_once();
		end

		repeat (4) @(negedge mclk_i);
		$display("value errors: %0d, other failures: %0d", err_count, fail_count);
		if (err_count == 0 && fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/opn_apb_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module opn_apb_slave import opn_bus_pkg::*, opn_reg_pkg::*; (
	input wire logic mclk_i,
	input wire logic arst_n_i,
	input wire apb_req_t apb_i,
	input wire logic [1:0] status_i, // A in bit 0, B in bit 1
	output logic [pdata_w-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output reg_wr_t wr_o
);

	logic setup_q;
	logic access;
	logic bank;
	logic [7:0] reg_num;
	logic known_reg;
	logic bad_wr;

	// an access phase only counts once after a setup phase
	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= apb_i.psel & ~apb_i.penable;
		end
	end

	assign access = apb_i.psel & apb_i.penable;
	assign bank = apb_i.paddr[paddr_w-1];
	assign reg_num = apb_i.paddr[7:0];

	always_comb begin
		case (reg_num)
			reg_timer_a_lo,
			reg_timer_a_hi,
			reg_timer_b,
			reg_timer_ctrl: known_reg = 1'b1;
			default: known_reg = 1'b0;
		endcase
	end

	assign bad_wr = bank | ~known_reg;

	assign pready_o = access; // zero wait states
	assign pslverr_o = access & apb_i.pwrite & bad_wr;

	// command is valid during the access phase so the register file takes it
	// at the edge that ends the transfer
	assign wr_o.valid = access & setup_q & apb_i.pwrite & ~bad_wr;
	assign wr_o.addr = reg_num;
	assign wr_o.data = apb_i.pwdata;

	// every address reads back the status byte
	assign prdata_o = {{(pdata_w-2){1'b0}}, status_i};

endmodule

`default_nettype wire

/* verilog/opn_bus_pkg.sv */
`default_nettype none

// host side of the timer block, an 8-bit APB slave
package opn_bus_pkg;

	// bit 8 selects the bank, bits 7:0 are the register number
	localparam int paddr_w = 9;

	localparam int pdata_w = 8;

	// one APB request as driven by the host
	// pready, pslverr and prdata come back as separate signals
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [paddr_w-1:0] paddr;
		logic [pdata_w-1:0] pwdata;
	} apb_req_t;

endpackage

`default_nettype wire

/* verilog/opn_reg_pkg.sv */
`default_nettype none

// register map of the global timer block
package opn_reg_pkg;

	// register numbers in bank 0
	localparam logic [7:0] reg_timer_a_lo = 8'h24; // timer A bits 7:0
	localparam logic [7:0] reg_timer_a_hi = 8'h25; // timer A bits 9:8
	localparam logic [7:0] reg_timer_b = 8'h26;
	localparam logic [7:0] reg_timer_ctrl = 8'h27; // load, enable, reset, mode

	// counter widths
	localparam int timer_a_w = 10;
	localparam int timer_b_w = 8;
	localparam int timer_b_prescale_w = 4; // 16 sample ticks per B step

	// bit positions inside register 0x27
	localparam int ctrl_run_a = 0;
	localparam int ctrl_run_b = 1;
	localparam int ctrl_en_a = 2;
	localparam int ctrl_en_b = 3;
	localparam int ctrl_clr_a = 4;
	localparam int ctrl_clr_b = 5;
	localparam int ctrl_mode_lsb = 6; // two bits, 7:6

	// one register write as seen by the register file
	typedef struct packed {
		logic valid;
		logic [7:0] addr;
		logic [7:0] data;
	} reg_wr_t;

	// channel 3 mode field
	typedef enum logic [1:0] {
		mode_normal = 2'd0,
		mode_ch3 = 2'd1,
		mode_csm = 2'd2,
		mode_csm_alt = 2'd3 // ch3 special mode, no csm key on
	} timer_mode_e;

	// control of one timer
	typedef struct packed {
		logic run; // load bit, counter runs while set
		logic flag_en; // overflow may set the status flag
		logic flag_clr; // single cycle, clears the status flag
	} timer_cfg_t;

endpackage

`default_nettype wire

/* verilog/opn_timer.sv */
`timescale 1ns/10ps
`default_nettype none

// reloading up counter, prescale_w of 0 steps on every sample tick
module opn_timer import opn_reg_pkg::*; #(
	parameter int cnt_w = timer_a_w,
	parameter int prescale_w = 0
) (
	input wire logic mclk_i,
	input wire logic arst_n_i,
	input wire logic sample_tick_i,
	input wire logic [cnt_w-1:0] load_i,
	input wire timer_cfg_t cfg_i,
	output logic status_o
);

	logic step;
	logic run_q;
	logic start;
	logic ovf;
	logic [cnt_w-1:0] cnt_q;
	logic status_q;

	if (prescale_w == 0) begin : g_direct
		assign step = sample_tick_i;
	end else begin : g_prescale
		logic [prescale_w-1:0] pre_q;

		// free running from reset, not tied to run
		always_ff @(posedge mclk_i or negedge arst_n_i) begin
			if (!arst_n_i) begin
				pre_q <= '0;
			end else if (sample_tick_i) begin
				pre_q <= pre_q + 1'b1;
			end
		end

		assign step = sample_tick_i & (&pre_q); // tick that wraps the prescaler
	end

	assign start = cfg_i.run & ~run_q;

	// load on start takes priority over a step in the same cycle
	assign ovf = cfg_i.run & ~start & step & (&cnt_q);

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			run_q <= 1'b0;
		end else begin
			run_q <= cfg_i.run;
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (start) begin
			cnt_q <= load_i;
		end else if (cfg_i.run & step) begin
			if (ovf) begin
				cnt_q <= load_i; // reload instead of wrapping
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// clear wins over a simultaneous overflow
	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			status_q <= 1'b0;
		end else if (cfg_i.flag_clr) begin
			status_q <= 1'b0;
		end else if (ovf & cfg_i.flag_en) begin
			status_q <= 1'b1;
		end
	end

	assign status_o = status_q;

endmodule

`default_nettype wire

/* verilog/opn_timer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module opn_timer_ctrl import opn_bus_pkg::*, opn_reg_pkg::*; (
	input wire logic mclk_i,
	input wire logic arst_n_i,
	input wire apb_req_t apb_i,
	output logic [pdata_w-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire logic sample_tick_i, // one pulse per output sample
	output logic timer_a_status_o,
	output logic timer_b_status_o,
	output logic mode_ch3_o,
	output logic mode_csm_o
);

	reg_wr_t wr;
	logic [timer_a_w-1:0] timer_a_load;
	logic [timer_b_w-1:0] timer_b_load;
	timer_cfg_t timer_a_cfg;
	timer_cfg_t timer_b_cfg;
	timer_mode_e mode;

	opn_apb_slave i_apb_slave (
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.apb_i(apb_i),
		.status_i({timer_b_status_o, timer_a_status_o}),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.wr_o(wr)
	);

	opn_timer_regs i_timer_regs (
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.wr_i(wr),
		.timer_a_load_o(timer_a_load),
		.timer_b_load_o(timer_b_load),
		.timer_a_cfg_o(timer_a_cfg),
		.timer_b_cfg_o(timer_b_cfg),
		.mode_o(mode)
	);

	opn_timer #(.cnt_w(timer_a_w), .prescale_w(0)) timer_a (
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.sample_tick_i(sample_tick_i),
		.load_i(timer_a_load),
		.cfg_i(timer_a_cfg),
		.status_o(timer_a_status_o)
	);

	opn_timer #(.cnt_w(timer_b_w), .prescale_w(timer_b_prescale_w)) timer_b (
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.sample_tick_i(sample_tick_i),
		.load_i(timer_b_load),
		.cfg_i(timer_b_cfg),
		.status_o(timer_b_status_o)
	);

	assign mode_ch3_o = (mode != mode_normal); // any special ch3 mode
	assign mode_csm_o = (mode == mode_csm);

endmodule

`default_nettype wire

/* verilog/opn_timer_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module opn_timer_regs import opn_reg_pkg::*; (
	input wire logic mclk_i,
	input wire logic arst_n_i,
	input wire reg_wr_t wr_i,
	output logic [timer_a_w-1:0] timer_a_load_o,
	output logic [timer_b_w-1:0] timer_b_load_o,
	output timer_cfg_t timer_a_cfg_o,
	output timer_cfg_t timer_b_cfg_o,
	output timer_mode_e mode_o
);

	logic wr_a_lo;
	logic wr_a_hi;
	logic wr_b;
	logic wr_ctrl;

	logic [7:0] a_lo_q;
	logic [timer_a_w-9:0] a_hi_q;
	logic [timer_b_w-1:0] b_q;
	logic run_a_q;
	logic run_b_q;
	logic en_a_q;
	logic en_b_q;
	logic clr_a_q;
	logic clr_b_q;
	timer_mode_e mode_q;

	assign wr_a_lo = wr_i.valid && (wr_i.addr == reg_timer_a_lo);
	assign wr_a_hi = wr_i.valid && (wr_i.addr == reg_timer_a_hi);
	assign wr_b = wr_i.valid && (wr_i.addr == reg_timer_b);
	assign wr_ctrl = wr_i.valid && (wr_i.addr == reg_timer_ctrl);

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			a_lo_q <= '0;
			a_hi_q <= '0;
			b_q <= '0;
		end else begin
			if (wr_a_lo) a_lo_q <= wr_i.data;
			if (wr_a_hi) a_hi_q <= wr_i.data[timer_a_w-9:0]; // upper bits ignored
			if (wr_b) b_q <= wr_i.data[timer_b_w-1:0];
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			en_a_q <= 1'b0;
			en_b_q <= 1'b0;
			mode_q <= mode_normal;
		end else if (wr_ctrl) begin
			run_a_q <= wr_i.data[ctrl_run_a];
			run_b_q <= wr_i.data[ctrl_run_b];
			en_a_q <= wr_i.data[ctrl_en_a];
			en_b_q <= wr_i.data[ctrl_en_b];
			mode_q <= timer_mode_e'(wr_i.data[ctrl_mode_lsb +: 2]);
		end
	end

	// reset bits are not stored, they only live for the cycle after the write
	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clr_a_q <= 1'b0;
			clr_b_q <= 1'b0;
		end else begin
			clr_a_q <= wr_ctrl & wr_i.data[ctrl_clr_a];
			clr_b_q <= wr_ctrl & wr_i.data[ctrl_clr_b];
		end
	end

	assign timer_a_load_o = {a_hi_q, a_lo_q};
	assign timer_b_load_o = b_q;

	assign timer_a_cfg_o = '{run: run_a_q, flag_en: en_a_q, flag_clr: clr_a_q};
	assign timer_b_cfg_o = '{run: run_b_q, flag_en: en_b_q, flag_clr: clr_b_q};

	assign mode_o = mode_q;

endmodule

`default_nettype wire
